//--- pat_alu.sv
`timescale 1ns/1ps
`include "pat_config.svh"

module pat_alu
	import pat_pkg::*;
(
	input  pat_op_t   i_op,
	input  pat_data_t i_a,
	input  pat_data_t i_b,
	output pat_data_t o_y
);

	localparam pat_data_t ONES = '1;

	logic [2:0] amt;       // shift by one to four
	pat_data_t  shl;
	pat_data_t  shr;
	pat_data_t  fill_low;  // vacated bits of a left shift
	pat_data_t  fill_high; // vacated bits of a right shift

	assign amt       = {1'b0, i_b[1:0]} + 3'd1;
	assign shl       = i_a << amt;
	assign shr       = i_a >> amt;
	assign fill_low  = ~(ONES << amt);
	assign fill_high = ~(ONES >> amt);

	always_comb
	begin
		case (i_op)
			`PAT_OP_OR:   o_y = i_a | i_b;
			`PAT_OP_AND:  o_y = i_a & i_b;
			`PAT_OP_ADD:  o_y = i_a + i_b;
			`PAT_OP_SUB:  o_y = i_a - i_b;
			`PAT_OP_NOT:  o_y = ~i_a;
			`PAT_OP_IN:   o_y = i_b;             // input port value
			`PAT_OP_SHLZ: o_y = shl;
			`PAT_OP_SHLO: o_y = shl | fill_low;
			`PAT_OP_SHRZ: o_y = shr;
			`PAT_OP_SHRO: o_y = shr | fill_high;
			default:      o_y = '0;
		endcase
	end

endmodule

//--- pat_config.svh
`ifndef PAT_CONFIG_SVH
`define PAT_CONFIG_SVH

// ======================================================================
// datapath widths
// ======================================================================
`define PAT_DATA_WIDTH      8
`define PAT_REG_ADR_WIDTH   3   // register file holds 2**3 entries
`define PAT_INSTR_ADR_WIDTH 10
`define PAT_INSTR_WIDTH     17

// instruction word layout from msb down
`define PAT_RN_MSB    16
`define PAT_RN_LSB    14
`define PAT_COND_MSB  13
`define PAT_COND_LSB  12
`define PAT_OP8_MSB   11
`define PAT_OP8_LSB   8
`define PAT_IMM8_MSB  7
`define PAT_IMM8_LSB  0
`define PAT_OP3_MSB   7   // i3 opcode overlays the top of imm8
`define PAT_OP3_LSB   4
`define PAT_IMM3_MSB  2
`define PAT_IMM3_LSB  0
`define PAT_OP0_MSB   3   // i0 opcode overlays the bottom of imm8
`define PAT_OP0_LSB   0

`define PAT_OP_PREFIX 4'hf  // escape into the next opcode space

// ======================================================================
// opcodes
// ======================================================================
`define PAT_I8_ORI   4'h0
`define PAT_I8_ORR   4'h1
`define PAT_I8_ANDI  4'h2
`define PAT_I8_ANDR  4'h3
`define PAT_I8_ADDI  4'h4
`define PAT_I8_ADDR  4'h5
`define PAT_I8_SUBI  4'h6
`define PAT_I8_SUBR  4'h7
`define PAT_I8_LDI   4'h8
`define PAT_I8_BF    4'hd
`define PAT_I8_CALL  4'he

`define PAT_I3_SHLZI 4'h0
`define PAT_I3_SHLZR 4'h1
`define PAT_I3_SHLOI 4'h2
`define PAT_I3_SHLOR 4'h3
`define PAT_I3_SHRZI 4'h4
`define PAT_I3_SHRZR 4'h5
`define PAT_I3_SHROI 4'h6
`define PAT_I3_SHROR 4'h7
`define PAT_I3_IN    4'h8
`define PAT_I3_OUT   4'hb

`define PAT_I0_NOT   4'h0
`define PAT_I0_TEST  4'h2
`define PAT_I0_RET   4'h3
`define PAT_I0_NOP   4'h5

// condition codes
`define PAT_COND_Z   2'd0
`define PAT_COND_NZ  2'd1
`define PAT_COND_N   2'd2
`define PAT_COND_AL  2'd3

`define PAT_BRANCH_SHADOW 3   // commits squashed after a taken jump

// decoded operation classes
`define PAT_OP_NOP   5'd0
`define PAT_OP_OR    5'd1
`define PAT_OP_AND   5'd2
`define PAT_OP_ADD   5'd3
`define PAT_OP_SUB   5'd4
`define PAT_OP_SHLZ  5'd5
`define PAT_OP_SHLO  5'd6
`define PAT_OP_SHRZ  5'd7
`define PAT_OP_SHRO  5'd8
`define PAT_OP_NOT   5'd9
`define PAT_OP_IN    5'd10
`define PAT_OP_OUT   5'd11
`define PAT_OP_TEST  5'd12
`define PAT_OP_BF    5'd13
`define PAT_OP_CALL  5'd14
`define PAT_OP_RET   5'd15

`endif

//--- pat_core.sv
`timescale 1ns/1ps

module pat_core
	import pat_pkg::*;
(
	input  logic           clk,
	input  logic           reset,
	input  pat_instr_t     i_instruction,
	input  pat_data_t      i_in0,
	input  pat_data_t      i_in1,
	input  pat_data_t      i_in2,
	output pat_instr_adr_t o_pc,
	output logic           o_jump,
	output pat_data_t      o_out_data,
	output logic           o_out_valid
);

	pat_reg_adr_t   rd_adr;
	pat_data_t      rd_data;
	logic           wb_en;
	pat_reg_adr_t   wb_adr;
	pat_data_t      wb_data;
	logic           jump_rel;
	logic           jump_ret;
	logic           call;
	pat_instr_adr_t jump_base;
	pat_data_t      jump_offset;

	pat_stage_if i_stage_if ();

	pat_reg_file i_reg_file
	(
		.clk       (clk),
		.i_rd_adr  (rd_adr),
		.i_wr_en   (wb_en),
		.i_wr_adr  (wb_adr),
		.i_wr_data (wb_data),
		.o_rd_data (rd_data)
	);

	pat_decode i_decode
	(
		.clk           (clk),
		.reset         (reset),
		.i_instruction (i_instruction),
		.i_fetch_pc    (o_pc),
		.i_in0         (i_in0),
		.i_in1         (i_in1),
		.i_in2         (i_in2),
		.i_rd_data     (rd_data),
		.i_wb_en       (wb_en),
		.i_wb_adr      (wb_adr),
		.i_wb_data     (wb_data),
		.o_rd_adr      (rd_adr),
		.stage         (i_stage_if.decode)
	);

	pat_execute i_execute
	(
		.clk           (clk),
		.reset         (reset),
		.stage         (i_stage_if.execute),
		.o_wb_en       (wb_en),
		.o_wb_adr      (wb_adr),
		.o_wb_data     (wb_data),
		.o_jump_rel    (jump_rel),
		.o_jump_ret    (jump_ret),
		.o_call        (call),
		.o_jump_base   (jump_base),
		.o_jump_offset (jump_offset),
		.o_jump        (o_jump),
		.o_out_data    (o_out_data),
		.o_out_valid   (o_out_valid)
	);

	pat_program_counter i_program_counter
	(
		.clk           (clk),
		.reset         (reset),
		.i_jump_rel    (jump_rel),
		.i_jump_ret    (jump_ret),
		.i_call        (call),
		.i_jump_base   (jump_base),
		.i_jump_offset (jump_offset),
		.o_pc          (o_pc)
	);

endmodule

//--- pat_decode.sv
`timescale 1ns/1ps
`include "pat_config.svh"

module pat_decode
	import pat_pkg::*;
(
	input  logic           clk,
	input  logic           reset,
	input  pat_instr_t     i_instruction,
	input  pat_instr_adr_t i_fetch_pc,
	input  pat_data_t      i_in0,
	input  pat_data_t      i_in1,
	input  pat_data_t      i_in2,
	input  pat_data_t      i_rd_data,
	input  logic           i_wb_en,
	input  pat_reg_adr_t   i_wb_adr,
	input  pat_data_t      i_wb_data,
	output pat_reg_adr_t   o_rd_adr,
	pat_stage_if.decode    stage
);

	pat_instr_adr_t fetch_pc_d; // address that i_instruction answers
	pat_instr_t     instr_q;
	pat_instr_adr_t instr_pc_q;

	pat_reg_adr_t rn;
	pat_cond_t    cond;
	logic [3:0]   op8;
	logic [3:0]   op3;
	logic [3:0]   op0;
	logic [7:0]   imm8;
	logic [2:0]   imm3;

	logic      is_i8;
	logic      is_i3;
	logic      reg_form;
	pat_op_t   op;
	pat_data_t rn_val;
	pat_data_t imm_val;
	pat_data_t in_val;
	pat_data_t a_next;
	pat_data_t b_next;

	always_ff @(posedge clk)
	begin
		fetch_pc_d <= i_fetch_pc;
		instr_q    <= i_instruction;
		instr_pc_q <= fetch_pc_d;
	end

	assign rn   = instr_q[`PAT_RN_MSB:`PAT_RN_LSB];
	assign cond = instr_q[`PAT_COND_MSB:`PAT_COND_LSB];
	assign op8  = instr_q[`PAT_OP8_MSB:`PAT_OP8_LSB];
	assign imm8 = instr_q[`PAT_IMM8_MSB:`PAT_IMM8_LSB];
	assign op3  = imm8[`PAT_OP3_MSB:`PAT_OP3_LSB];
	assign imm3 = imm8[`PAT_IMM3_MSB:`PAT_IMM3_LSB];
	assign op0  = imm8[`PAT_OP0_MSB:`PAT_OP0_LSB];

	assign is_i8 = (op8 != `PAT_OP_PREFIX);
	assign is_i3 = !is_i8 && (op3 != `PAT_OP_PREFIX);

	// odd opcodes below 8 take a register operand in i8 and i3 space
	assign reg_form = (is_i8 && !op8[3] && op8[0]) || (is_i3 && !op3[3] && op3[0]);

	// ==================================================================
	// operation class
	// ==================================================================
	always_comb
	begin
		op = `PAT_OP_NOP;
		if (is_i8)
		begin
			case (op8)
				`PAT_I8_ORI, `PAT_I8_ORR:   op = `PAT_OP_OR;
				`PAT_I8_ANDI, `PAT_I8_ANDR: op = `PAT_OP_AND;
				`PAT_I8_ADDI, `PAT_I8_ADDR: op = `PAT_OP_ADD;
				`PAT_I8_SUBI, `PAT_I8_SUBR: op = `PAT_OP_SUB;
				`PAT_I8_LDI:                op = `PAT_OP_OR; // or with zero
				`PAT_I8_BF:                 op = `PAT_OP_BF;
				`PAT_I8_CALL:               op = `PAT_OP_CALL;
				default:                    op = `PAT_OP_NOP;
			endcase
		end
		else if (is_i3)
		begin
			case (op3)
				`PAT_I3_SHLZI, `PAT_I3_SHLZR: op = `PAT_OP_SHLZ;
				`PAT_I3_SHLOI, `PAT_I3_SHLOR: op = `PAT_OP_SHLO;
				`PAT_I3_SHRZI, `PAT_I3_SHRZR: op = `PAT_OP_SHRZ;
				`PAT_I3_SHROI, `PAT_I3_SHROR: op = `PAT_OP_SHRO;
				`PAT_I3_IN:                   op = `PAT_OP_IN;
				`PAT_I3_OUT:                  op = `PAT_OP_OUT;
				default:                      op = `PAT_OP_NOP;
			endcase
		end
		else
		begin
			case (op0)
				`PAT_I0_NOT:  op = `PAT_OP_NOT;
				`PAT_I0_TEST: op = `PAT_OP_TEST;
				`PAT_I0_RET:  op = `PAT_OP_RET;
				`PAT_I0_NOP:  op = `PAT_OP_NOP;
				default:      op = `PAT_OP_NOP;
			endcase
		end
	end

	// ==================================================================
	// operand selection
	// ==================================================================
	assign o_rd_adr = rn;

	// the instruction ahead commits at the same edge this one is registered
	assign rn_val  = (i_wb_en && (i_wb_adr == rn)) ? i_wb_data : i_rd_data;
	assign imm_val = is_i8 ? imm8 : {{(`PAT_DATA_WIDTH-3){1'b0}}, imm3};

	always_comb
	begin
		case (imm3) // one-hot port select
			3'b001:  in_val = i_in0;
			3'b010:  in_val = i_in1;
			3'b100:  in_val = i_in2;
			default: in_val = i_in0;
		endcase
	end

	assign a_next = (is_i8 && (op8 == `PAT_I8_LDI)) ? '0 : rn_val;

	always_comb
	begin
		if (op == `PAT_OP_IN)
			b_next = in_val;
		else if (reg_form)
			b_next = rn_val;
		else
			b_next = imm_val;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			stage.valid <= 1'b0;
		else
			stage.valid <= 1'b1; // no stalls, a slot every cycle
	end

	always_ff @(posedge clk)
	begin
		stage.op       <= op;
		stage.rd       <= rn;
		stage.cond     <= cond;
		stage.a        <= a_next;
		stage.b        <= b_next;
		stage.imm_form <= !reg_form;
		stage.pc       <= instr_pc_q;
	end

endmodule

//--- pat_execute.sv
`timescale 1ns/1ps
`include "pat_config.svh"

module pat_execute
	import pat_pkg::*;
(
	input  logic           clk,
	input  logic           reset,
	pat_stage_if.execute   stage,
	output logic           o_wb_en,
	output pat_reg_adr_t   o_wb_adr,
	output pat_data_t      o_wb_data,
	output logic           o_jump_rel,
	output logic           o_jump_ret,
	output logic           o_call,
	output pat_instr_adr_t o_jump_base,
	output pat_data_t      o_jump_offset,
	output logic           o_jump,
	output pat_data_t      o_out_data,
	output logic           o_out_valid
);

	localparam int SHADOW_W = $clog2(`PAT_BRANCH_SHADOW + 1);

	pat_ctrl_state_t     state;
	logic [SHADOW_W-1:0] shadow_cnt;

	pat_data_t acc;
	logic      z;
	logic      n;

	logic      cond_ok;
	logic      commit;
	logic      result_op;
	logic      take_jump;
	pat_data_t alu_a;
	pat_data_t alu_y;

	always_comb
	begin
		cond_ok = 1'b0;
		case (stage.cond)
			`PAT_COND_Z:  cond_ok = z;
			`PAT_COND_NZ: cond_ok = !z;
			`PAT_COND_N:  cond_ok = n;
			`PAT_COND_AL: cond_ok = 1'b1;
		endcase
	end

	assign commit = stage.valid && cond_ok && (state == CTRL_RUN);

	always_comb
	begin
		case (stage.op)
			`PAT_OP_OR, `PAT_OP_AND, `PAT_OP_ADD, `PAT_OP_SUB,
			`PAT_OP_SHLZ, `PAT_OP_SHLO, `PAT_OP_SHRZ, `PAT_OP_SHRO,
			`PAT_OP_NOT, `PAT_OP_IN:
				result_op = 1'b1;
			default:
				result_op = 1'b0;
		endcase
	end

	// ==================================================================
	// alu and write-back
	// ==================================================================
	assign alu_a = stage.imm_form ? stage.a : acc; // register forms work on acc

	pat_alu i_alu
	(
		.i_op (stage.op),
		.i_a  (alu_a),
		.i_b  (stage.b),
		.o_y  (alu_y)
	);

	assign o_wb_en   = commit && result_op;
	assign o_wb_adr  = stage.rd;
	assign o_wb_data = alu_y;

	// jump request goes straight to the pc for this edge
	assign o_jump_rel    = commit && ((stage.op == `PAT_OP_BF) || (stage.op == `PAT_OP_CALL));
	assign o_jump_ret    = commit && (stage.op == `PAT_OP_RET);
	assign o_call        = commit && (stage.op == `PAT_OP_CALL);
	assign o_jump_base   = stage.pc;
	assign o_jump_offset = stage.b;
	assign take_jump     = o_jump_rel || o_jump_ret;

	// ==================================================================
	// state, flags and output port
	// ==================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state       <= CTRL_FLUSH; // stale fetches are in flight
			shadow_cnt  <= SHADOW_W'(`PAT_BRANCH_SHADOW);
			acc         <= '0;
			z           <= 1'b0;
			n           <= 1'b0;
			o_jump      <= 1'b0;
			o_out_valid <= 1'b0;
		end
		else
		begin
			o_jump      <= take_jump;
			o_out_valid <= commit && (stage.op == `PAT_OP_OUT);
			if (o_wb_en)
				acc <= alu_y;
			if (commit && (stage.op == `PAT_OP_TEST))
			begin
				z <= (stage.a == '0);
				n <= stage.a[`PAT_DATA_WIDTH-1];
			end
			case (state)
				CTRL_RUN:
				begin
					if (take_jump)
					begin
						state      <= CTRL_FLUSH;
						shadow_cnt <= SHADOW_W'(`PAT_BRANCH_SHADOW);
					end
				end
				CTRL_FLUSH:
				begin
					shadow_cnt <= shadow_cnt - 1'b1; // one squashed slot per cycle
					if (shadow_cnt == SHADOW_W'(1))
						state <= CTRL_RUN;
				end
				default:
					state <= CTRL_FLUSH;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (commit && (stage.op == `PAT_OP_OUT))
			o_out_data <= stage.a;
	end

endmodule

//--- pat_pkg.sv
`include "pat_config.svh"

package pat_pkg;

	// ==================================================================
	// datapath types
	// ==================================================================
	typedef logic [`PAT_DATA_WIDTH-1:0]      pat_data_t;      // one data word
	typedef logic [`PAT_REG_ADR_WIDTH-1:0]   pat_reg_adr_t;   // register file address
	typedef logic [`PAT_INSTR_ADR_WIDTH-1:0] pat_instr_adr_t; // program address
	typedef logic [`PAT_INSTR_WIDTH-1:0]     pat_instr_t;     // raw instruction word

	// condition field of every instruction
	typedef logic [1:0] pat_cond_t;

	// decoded operation class, see PAT_OP_* codes
	typedef logic [4:0] pat_op_t;

	// execute stage control
	typedef enum logic
	{
		CTRL_RUN,   // normal commit
		CTRL_FLUSH  // squashing the branch shadow
	} pat_ctrl_state_t;

endpackage

//--- pat_program_counter.sv
`timescale 1ns/1ps
`include "pat_config.svh"

module pat_program_counter
	import pat_pkg::*;
(
	input  logic           clk,
	input  logic           reset,
	input  logic           i_jump_rel,
	input  logic           i_jump_ret,
	input  logic           i_call,
	input  pat_instr_adr_t i_jump_base,
	input  pat_data_t      i_jump_offset,
	output pat_instr_adr_t o_pc
);

	pat_instr_adr_t pc_q;
	pat_instr_adr_t link_q; // single level, calls do not nest
	pat_instr_adr_t target;

	assign target = i_jump_base
		+ {{(`PAT_INSTR_ADR_WIDTH-`PAT_DATA_WIDTH){i_jump_offset[`PAT_DATA_WIDTH-1]}},
		i_jump_offset};

	always_ff @(posedge clk)
	begin
		if (reset)
			pc_q <= '0;
		else if (i_jump_rel)
			pc_q <= target;
		else if (i_jump_ret)
			pc_q <= link_q;
		else
			pc_q <= pc_q + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (i_call)
			link_q <= i_jump_base + 1'b1; // return to the word after the call
	end

	assign o_pc = pc_q;

endmodule

//--- pat_reg_file.sv
`timescale 1ns/1ps
`include "pat_config.svh"

module pat_reg_file
	import pat_pkg::*;
(
	input  logic         clk,
	input  pat_reg_adr_t i_rd_adr,
	input  logic         i_wr_en,
	input  pat_reg_adr_t i_wr_adr,
	input  pat_data_t    i_wr_data,
	output pat_data_t    o_rd_data
);

	localparam int DEPTH = 1 << `PAT_REG_ADR_WIDTH;

	pat_data_t regs [DEPTH];

	assign o_rd_data = regs[i_rd_adr]; // read port is combinational

	always_ff @(posedge clk)
	begin
		if (i_wr_en)
		begin
			regs[i_wr_adr] <= i_wr_data;
		end
	end

endmodule

//--- pat_stage_if.sv
`timescale 1ns/1ps

// one decoded instruction on its way from decode to execute
interface pat_stage_if
	import pat_pkg::*;
();

	logic           valid;
	pat_op_t        op;
	pat_reg_adr_t   rd;       // destination register, same as rn
	pat_cond_t      cond;
	pat_data_t      a;        // register value, zero for ldi
	pat_data_t      b;        // immediate, input port or register value
	logic           imm_form; // low for register forms that take the accumulator
	pat_instr_adr_t pc;       // address of this instruction

	modport decode
	(
		output valid, op, rd, cond, a, b, imm_form, pc
	);

	modport execute
	(
		input valid, op, rd, cond, a, b, imm_form, pc
	);

endinterface

//--- tb.f
+incdir+.
pat_pkg.sv
pat_stage_if.sv
pat_reg_file.sv
pat_decode.sv
pat_alu.sv
pat_execute.sv
pat_program_counter.sv
pat_core.sv
tb_clock_gen.sv
tb_pat.sv

//--- tb_clock_gen.sv
`timescale 1ns/1ps

// free running clock and a power-on reset
module tb_clock_gen
#(
	parameter realtime PERIOD       = 100.0,
	parameter int      RESET_CYCLES = 8
)
(
	output logic o_clk,
	output logic o_reset
);

	initial
	begin
		o_clk = 1'b0;
		forever
			#(PERIOD / 2.0) o_clk = ~o_clk;
	end

	initial
	begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_reset <= 1'b0; // released on a rising edge like the rest of the stimulus
	end

endmodule

//--- tb_pat.sv
`timescale 1ns/1ps
`include "pat_config.svh"

module tb_pat
	import pat_pkg::*;
();

	localparam int MEM_DEPTH  = 1 << `PAT_INSTR_ADR_WIDTH;
	localparam int RST_CYCLES = 8;
	localparam int MAX_STEPS  = 1000;

	logic clk;
	logic gen_reset;
	logic test_reset;
	logic dut_reset;

	pat_instr_t     instruction;
	pat_data_t      in0;
	pat_data_t      in1;
	pat_data_t      in2;
	pat_instr_adr_t pc;
	logic           jump;
	pat_data_t      out_data;
	logic           out_valid;

	pat_instr_t imem [MEM_DEPTH];
	int         wp;            // next free program address
	pat_data_t  in_vals [3];
	pat_data_t  exp_q [$];     // expected out values, oldest first
	logic [31:0] lfsr;

	pat_instr_adr_t jump_q [$]; // targets of taken jumps, the last one repeats
	logic           halt_seen;  // final jump to itself has shown up

	int cycle_budget;
	int errors;
	int test_errors;
	int checks;
	int tests_run;
	int tests_failed;

	tb_clock_gen #(.PERIOD(100.0), .RESET_CYCLES(RST_CYCLES)) i_clock_gen
	(
		.o_clk   (clk),
		.o_reset (gen_reset)
	);

	assign dut_reset = gen_reset | test_reset;

	pat_core i_pat_core
	(
		.clk           (clk),
		.reset         (dut_reset),
		.i_instruction (instruction),
		.i_in0         (in0),
		.i_in1         (in1),
		.i_in2         (in2),
		.o_pc          (pc),
		.o_jump        (jump),
		.o_out_data    (out_data),
		.o_out_valid   (out_valid)
	);

	// memory with one cycle of read latency
	always @(posedge clk)
		instruction <= imem[pc];

	// ======================================================================
	// helpers
	// ======================================================================
	function automatic logic [31:0] lfsr_bits(input int count);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < count; i++)
		begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps 32 22 2 1
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic pat_instr_t enc_i8(input pat_reg_adr_t rn, input pat_cond_t c,
		input logic [3:0] op, input logic [7:0] imm);
		return {rn, c, op, imm};
	endfunction

	function automatic pat_instr_t enc_i3(input pat_reg_adr_t rn, input pat_cond_t c,
		input logic [3:0] op, input logic [2:0] imm);
		return {rn, c, 4'hf, op, 1'b0, imm};
	endfunction

	function automatic pat_instr_t enc_i0(input pat_reg_adr_t rn, input pat_cond_t c,
		input logic [3:0] op);
		return {rn, c, 4'hf, 4'hf, op};
	endfunction

	task automatic put(input pat_instr_t w);
		imem[wp] = w;
		wp++;
	endtask

	task automatic clear_mem();
		pat_instr_adr_t a;
		for (int i = 0; i < MEM_DEPTH; i++)
		begin
			a       = pat_instr_adr_t'(i);
			imem[i] = {a[9:7], a[6:5], `PAT_I8_LDI, a[7:0]}; // harmless ldi fill
		end
		wp = 0;
	endtask

	// shift one bit at a time, kind is {right, fill one}
	function automatic pat_data_t shift_ref(input logic [1:0] kind, input pat_data_t v,
		input int amt);
		pat_data_t r;
		r = v;
		for (int i = 0; i < amt; i++)
		begin
			if (kind[1])
				r = {kind[0], r[7:1]};
			else
				r = {r[6:0], kind[0]};
		end
		return r;
	endfunction

	// ======================================================================
	// reference model, fills exp_q and jump_q and returns executed instructions
	// ======================================================================
	function automatic int pat_ref_run();
		pat_data_t      regs [8];
		pat_data_t      acc;
		pat_data_t      rv;
		pat_data_t      res;
		pat_instr_adr_t rpc;
		pat_instr_adr_t next_pc;
		pat_instr_adr_t link;
		pat_instr_t     w;
		logic           z;
		logic           n;
		logic           ok;
		logic           wr;
		logic [2:0]     rn;
		logic [1:0]     cnd;
		logic [3:0]     op8;
		logic [3:0]     op3;
		logic [3:0]     op0;
		logic [7:0]     imm8;
		int             steps;
		exp_q.delete();
		jump_q.delete();
		foreach (regs[i])
			regs[i] = '0;
		acc   = '0;
		z     = 1'b0;
		n     = 1'b0;
		rpc   = '0;
		link  = '0;
		steps = 0;
		while (steps < MAX_STEPS)
		begin
			w     = imem[rpc];
			rn    = w[16:14];
			cnd   = w[13:12];
			op8   = w[11:8];
			imm8  = w[7:0];
			op3   = imm8[7:4];
			op0   = imm8[3:0];
			steps++;
			ok      = (cnd == `PAT_COND_AL) || ((cnd == `PAT_COND_Z) && z)
				|| ((cnd == `PAT_COND_NZ) && !z) || ((cnd == `PAT_COND_N) && n);
			rv      = regs[rn];
			wr      = 1'b0;
			res     = '0;
			next_pc = rpc + 1'b1;
			if (ok && (op8 != 4'hf))
			begin
				wr = 1'b1;
				case (op8)
					`PAT_I8_ORI:  res = rv | imm8;
					`PAT_I8_ORR:  res = acc | rv;
					`PAT_I8_ANDI: res = rv & imm8;
					`PAT_I8_ANDR: res = acc & rv;
					`PAT_I8_ADDI: res = rv + imm8;
					`PAT_I8_ADDR: res = acc + rv;
					`PAT_I8_SUBI: res = rv - imm8;
					`PAT_I8_SUBR: res = acc - rv;
					`PAT_I8_LDI:  res = imm8;
					default:      wr = 1'b0;
				endcase
				if (op8 == `PAT_I8_CALL)
					link = rpc + 1'b1;
				if ((op8 == `PAT_I8_BF) || (op8 == `PAT_I8_CALL))
				begin
					next_pc = rpc + {{2{imm8[7]}}, imm8};
					jump_q.push_back(next_pc);
				end
				if ((op8 == `PAT_I8_BF) && (imm8 == 8'h00))
					return steps; // jump to itself ends the program
			end
			else if (ok && (op3 != 4'hf))
			begin
				if (op3 < 4'h8)
				begin
					wr = 1'b1;
					if (op3[0]) // register amount works on the accumulator
						res = shift_ref(op3[2:1], acc, rv[1:0] + 1);
					else
						res = shift_ref(op3[2:1], rv, imm8[1:0] + 1);
				end
				else if (op3 == `PAT_I3_IN)
				begin
					wr = 1'b1;
					case (imm8[2:0])
						3'b010:  res = in_vals[1];
						3'b100:  res = in_vals[2];
						default: res = in_vals[0];
					endcase
				end
				else if (op3 == `PAT_I3_OUT)
					exp_q.push_back(rv);
			end
			else if (ok)
			begin
				case (op0)
					`PAT_I0_NOT:
					begin
						wr  = 1'b1;
						res = ~rv;
					end
					`PAT_I0_TEST:
					begin
						z = (rv == '0);
						n = rv[7];
					end
					`PAT_I0_RET:
					begin
						next_pc = link;
						jump_q.push_back(link);
					end
					default: ;
				endcase
			end
			if (wr)
			begin
				regs[rn] = res;
				acc      = res;
			end
			rpc = next_pc;
		end
		return steps;
	endfunction

	// ======================================================================
	// checking
	// ======================================================================
	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			$display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
			errors++;
			test_errors++;
		end
	endtask

	// outputs are settled by the falling edge
	always @(negedge clk)
	begin
		if (!dut_reset && out_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("unexpected out of %h at %0t", out_data, $time);
				errors++;
				test_errors++;
			end
			else
				check_value("o_out_data", out_data, exp_q.pop_front());
		end
		if (!dut_reset && jump)
		begin
			if (jump_q.size() == 0)
			begin
				$display("unexpected jump to %h at %0t", pc, $time);
				errors++;
				test_errors++;
			end
			else
			begin
				check_value("o_pc", pc, jump_q[0]); // pc already redirected
				if (jump_q.size() > 1)
					jump_q.delete(0);
				else
					halt_seen = 1'b1;
			end
		end
	end

	initial
	begin
		int cycles;
		cycles = 0;
		while (cycles <= cycle_budget)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("watchdog expired after %0d cycles", cycles);
		$display("Simulation FAILED");
		$finish;
	end

	// ======================================================================
	// test sequencing
	// ======================================================================
	task automatic begin_test();
		@(posedge clk);
		test_reset <= 1'b1;
		@(posedge clk);
		clear_mem();
	endtask

	task automatic run_test(input string name);
		int executed;
		int allow;
		executed     = pat_ref_run();
		allow        = 8 * executed;
		cycle_budget = cycle_budget + allow + 32;
		test_errors  = 0;
		halt_seen    = 1'b0;
		in0 <= in_vals[0];
		in1 <= in_vals[1];
		in2 <= in_vals[2];
		repeat (RST_CYCLES) @(posedge clk);
		test_reset <= 1'b0;
		repeat (allow) @(posedge clk);
		if (exp_q.size() != 0)
		begin
			$display("%0d expected outs never appeared", exp_q.size());
			errors++;
			test_errors++;
		end
		if ((jump_q.size() > 1) || !halt_seen)
		begin
			$display("jump to %h never appeared", jump_q[0]);
			errors++;
			test_errors++;
		end
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("test %-12s %s, %0d instructions, %0d errors", name,
			(test_errors == 0) ? "ok" : "failed", executed, test_errors);
	endtask

	task automatic prog_imm_ops();
		put(enc_i8(3'd1, `PAT_COND_AL, `PAT_I8_LDI, lfsr_bits(8)));
		put(enc_i3(3'd1, `PAT_COND_AL, `PAT_I3_OUT, 3'd0));
		put(enc_i8(3'd1, `PAT_COND_AL, `PAT_I8_ORI, lfsr_bits(8)));
		put(enc_i3(3'd1, `PAT_COND_AL, `PAT_I3_OUT, 3'd0));
		put(enc_i8(3'd1, `PAT_COND_AL, `PAT_I8_ANDI, lfsr_bits(8)));
		put(enc_i3(3'd1, `PAT_COND_AL, `PAT_I3_OUT, 3'd0));
		put(enc_i8(3'd1, `PAT_COND_AL, `PAT_I8_ADDI, lfsr_bits(8)));
		put(enc_i3(3'd1, `PAT_COND_AL, `PAT_I3_OUT, 3'd0));
		put(enc_i8(3'd1, `PAT_COND_AL, `PAT_I8_SUBI, lfsr_bits(8)));
		put(enc_i3(3'd1, `PAT_COND_AL, `PAT_I3_OUT, 3'd0));
		// chain on r2 with no gap between results
		put(enc_i8(3'd2, `PAT_COND_AL, `PAT_I8_LDI, lfsr_bits(8)));
		put(enc_i8(3'd2, `PAT_COND_AL, `PAT_I8_ADDI, lfsr_bits(8)));
		put(enc_i8(3'd2, `PAT_COND_AL, `PAT_I8_SUBI, lfsr_bits(8)));
		put(enc_i8(3'd2, `PAT_COND_AL, `PAT_I8_ORI, lfsr_bits(8)));
		put(enc_i3(3'd2, `PAT_COND_AL, `PAT_I3_OUT, 3'd0));
		put(enc_i8(3'd0, `PAT_COND_AL, `PAT_I8_BF, 8'h00));
	endtask

	task automatic prog_reg_shift();
		logic [3:0] sh_ops [8];
		sh_ops = '{`PAT_I3_SHLZI, `PAT_I3_SHLOI, `PAT_I3_SHRZI, `PAT_I3_SHROI,
			`PAT_I3_SHLZR, `PAT_I3_SHLOR, `PAT_I3_SHRZR, `PAT_I3_SHROR};
		put(enc_i8(3'd3, `PAT_COND_AL, `PAT_I8_LDI, lfsr_bits(8)));
		put(enc_i8(3'd1, `PAT_COND_AL, `PAT_I8_LDI, lfsr_bits(8)));
		put(enc_i8(3'd3, `PAT_COND_AL, `PAT_I8_ORR, 8'h00));
		put(enc_i3(3'd3, `PAT_COND_AL, `PAT_I3_OUT, 3'd0));
		put(enc_i8(3'd4, `PAT_COND_AL, `PAT_I8_LDI, lfsr_bits(8)));
		put(enc_i8(3'd3, `PAT_COND_AL, `PAT_I8_ANDR, 8'h00));
		put(enc_i3(3'd3, `PAT_COND_AL, `PAT_I3_OUT, 3'd0));
		put(enc_i8(3'd1, `PAT_COND_AL, `PAT_I8_ADDR, 8'h00));
		put(enc_i3(3'd1, `PAT_COND_AL, `PAT_I3_OUT, 3'd0));
		put(enc_i8(3'd4, `PAT_COND_AL, `PAT_I8_SUBR, 8'h00));
		put(enc_i3(3'd4, `PAT_COND_AL, `PAT_I3_OUT, 3'd0));
		for (int i = 0; i < 8; i++)
		begin
			if (i == 4)
				put(enc_i8(3'd5, `PAT_COND_AL, `PAT_I8_LDI, lfsr_bits(8)));
			put(enc_i3((i < 4) ? 3'd1 : 3'd5, `PAT_COND_AL, sh_ops[i], lfsr_bits(3)));
			put(enc_i3((i < 4) ? 3'd1 : 3'd5, `PAT_COND_AL, `PAT_I3_OUT, 3'd0));
		end
		put(enc_i0(3'd5, `PAT_COND_AL, `PAT_I0_NOT));
		put(enc_i3(3'd5, `PAT_COND_AL, `PAT_I3_OUT, 3'd0));
		put(enc_i8(3'd0, `PAT_COND_AL, `PAT_I8_BF, 8'h00));
	endtask

	task automatic prog_conditions();
		put(enc_i8(3'd1, `PAT_COND_AL, `PAT_I8_LDI, 8'h00));
		put(enc_i8(3'd2, `PAT_COND_AL, `PAT_I8_LDI, lfsr_bits(8)));
		put(enc_i0(3'd1, `PAT_COND_AL, `PAT_I0_TEST));              // z set
		put(enc_i8(3'd2, `PAT_COND_Z, `PAT_I8_ADDI, lfsr_bits(8)));
		put(enc_i3(3'd2, `PAT_COND_Z, `PAT_I3_OUT, 3'd0));
		put(enc_i8(3'd2, `PAT_COND_NZ, `PAT_I8_LDI, lfsr_bits(8))); // skipped
		put(enc_i3(3'd2, `PAT_COND_NZ, `PAT_I3_OUT, 3'd0));         // skipped
		put(enc_i8(3'd3, `PAT_COND_AL, `PAT_I8_LDI, 8'h80 | lfsr_bits(8)));
		put(enc_i0(3'd3, `PAT_COND_AL, `PAT_I0_TEST));              // n set
		put(enc_i3(3'd3, `PAT_COND_N, `PAT_I3_OUT, 3'd0));
		put(enc_i8(3'd2, `PAT_COND_Z, `PAT_I8_LDI, lfsr_bits(8)));  // skipped
		put(enc_i3(3'd2, `PAT_COND_AL, `PAT_I3_OUT, 3'd0));
		put(enc_i8(3'd4, `PAT_COND_AL, `PAT_I8_LDI, 8'h11));
		put(enc_i0(3'd4, `PAT_COND_AL, `PAT_I0_TEST));
		put(enc_i3(3'd4, `PAT_COND_N, `PAT_I3_OUT, 3'd0));          // skipped
		put(enc_i3(3'd4, `PAT_COND_NZ, `PAT_I3_OUT, 3'd0));
		put(enc_i8(3'd0, `PAT_COND_AL, `PAT_I8_BF, 8'h00));
	endtask

	task automatic prog_loop();
		put(enc_i8(3'd2, `PAT_COND_AL, `PAT_I8_LDI, lfsr_bits(8)));
		put(enc_i8(3'd1, `PAT_COND_AL, `PAT_I8_LDI, 8'd2 + lfsr_bits(2)));
		put(enc_i3(3'd1, `PAT_COND_AL, `PAT_I3_OUT, 3'd0));   // loop head
		put(enc_i8(3'd1, `PAT_COND_AL, `PAT_I8_SUBI, 8'd1));
		put(enc_i0(3'd1, `PAT_COND_AL, `PAT_I0_TEST));
		put(enc_i8(3'd0, `PAT_COND_NZ, `PAT_I8_BF, 8'hfd));   // back to the head
		put(enc_i8(3'd0, `PAT_COND_AL, `PAT_I8_BF, 8'h04));   // over the shadow
		put(enc_i3(3'd2, `PAT_COND_AL, `PAT_I3_OUT, 3'd0));
		put(enc_i3(3'd2, `PAT_COND_AL, `PAT_I3_OUT, 3'd0));
		put(enc_i3(3'd2, `PAT_COND_AL, `PAT_I3_OUT, 3'd0));
		put(enc_i3(3'd1, `PAT_COND_AL, `PAT_I3_OUT, 3'd0));
		put(enc_i8(3'd0, `PAT_COND_AL, `PAT_I8_BF, 8'h00));
	endtask

	task automatic prog_call();
		put(enc_i8(3'd1, `PAT_COND_AL, `PAT_I8_LDI, lfsr_bits(8)));
		put(enc_i8(3'd2, `PAT_COND_AL, `PAT_I8_LDI, 8'h00));
		put(enc_i8(3'd0, `PAT_COND_AL, `PAT_I8_CALL, 8'h04)); // subroutine at 6
		put(enc_i3(3'd2, `PAT_COND_AL, `PAT_I3_OUT, 3'd0));
		put(enc_i8(3'd0, `PAT_COND_AL, `PAT_I8_BF, 8'h00));
		wp++;
		put(enc_i8(3'd2, `PAT_COND_AL, `PAT_I8_LDI, lfsr_bits(8)));
		put(enc_i3(3'd1, `PAT_COND_AL, `PAT_I3_OUT, 3'd0));
		put(enc_i0(3'd0, `PAT_COND_AL, `PAT_I0_RET));
	endtask

	task automatic prog_inputs();
		logic [2:0] sel [4];
		sel = '{3'b001, 3'b010, 3'b100, 3'b000};
		for (int i = 0; i < 3; i++)
			in_vals[i] = lfsr_bits(8);
		for (int i = 0; i < 4; i++)
		begin
			put(enc_i3(pat_reg_adr_t'(i + 1), `PAT_COND_AL, `PAT_I3_IN, sel[i]));
			put(enc_i3(pat_reg_adr_t'(i + 1), `PAT_COND_AL, `PAT_I3_OUT, 3'd0));
		end
		put(enc_i8(3'd0, `PAT_COND_AL, `PAT_I8_BF, 8'h00));
	endtask

	initial
	begin
		instruction  = '0;
		in0          = '0;
		in1          = '0;
		in2          = '0;
		test_reset   = 1'b0;
		lfsr         = 32'hf7a7_7751;
		cycle_budget = 32;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		halt_seen    = 1'b0;
		in_vals      = '{8'h00, 8'h00, 8'h00};
		clear_mem();

		begin_test();
		prog_imm_ops();
		run_test("imm_ops");
		begin_test();
		prog_reg_shift();
		run_test("reg_shift");
		begin_test();
		prog_conditions();
		run_test("conditions");
		begin_test();
		prog_loop();
		run_test("loop");
		begin_test();
		prog_call();
		run_test("call");
		begin_test();
		prog_inputs();
		run_test("inputs");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
